// File: Makefile
TOP = tb_uart_dbg

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
src/uart_dbg_pkg.sv
src/uart_rx.sv
src/byte_fifo.sv
src/dbg_cmd_engine.sv
src/uart_tx.sv
src/uart_dbg_top.sv
verification/tb_uart_dbg.sv

// File: src/byte_fifo.sv
// Receive byte FIFO
module byte_fifo (
  input  logic                       clk,
  input  logic                       reset_i,
  input  uart_dbg_pkg::byte_strobe_t push_i,
  input  logic                       pop_i,
  output logic [7:0]                 head_o,
  output logic                       empty_o
);

  import uart_dbg_pkg::*;

  logic [7:0]            mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  // Bytes arriving while full are dropped
  assign do_push = push_i.valid && !full;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_i.data;
    end
  end

  assign head_o = mem_q[rd_ptr_q];

endmodule

// File: src/dbg_cmd_engine.sv
// Debug command engine
module dbg_cmd_engine (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic [7:0]                 head_i,
  input  logic                       empty_i,
  output logic                       pop_o,
  output uart_dbg_pkg::byte_strobe_t tx_req_o,
  input  logic                       tx_busy_i
);

  import uart_dbg_pkg::*;

  engine_state_e         state_q;
  logic                  is_cmd_q;
  logic                  is_write_q;
  logic [FIELD_CNT_W-1:0] field_cnt_q;
  logic                  field_last;
  logic [MEM_ADDR_W-1:0] addr_q;
  dbg_len_t              len_q;
  logic [7:0]            mem_q [MEM_BYTES];
  logic                  step;

  assign field_last = (field_cnt_q == FIELD_CNT_W'(FIELD_BYTES - 1));

  // Pops and reply requests
  always_comb begin
    pop_o    = 1'b0;
    tx_req_o = '0;
    unique case (state_q)
      IDLE, GET_ADDR, GET_LEN: begin
        pop_o = !empty_i;
      end
      SEND_ACK: begin
        tx_req_o.valid = !tx_busy_i;
        tx_req_o.data  = CTRL_ACK;
      end
      XFER: begin
        if (is_write_q) begin
          pop_o = !empty_i;
        end else begin
          tx_req_o.valid = !tx_busy_i;
          tx_req_o.data  = mem_q[addr_q];
        end
      end
      SEND_EOT: begin
        tx_req_o.valid = !tx_busy_i;
        tx_req_o.data  = CTRL_EOT;
      end
      default: ;
    endcase
  end

  // One data byte moves per step
  assign step = (state_q == XFER) && (pop_o || tx_req_o.valid);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q     <= IDLE;
      is_cmd_q    <= 1'b0;
      is_write_q  <= 1'b0;
      field_cnt_q <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (pop_o) begin
            case (head_i)
              CTRL_ACK: begin
                is_cmd_q <= 1'b0;
                state_q  <= SEND_ACK;
              end
              CMD_READ, CMD_WRITE: begin
                is_cmd_q    <= 1'b1;
                is_write_q  <= (head_i == CMD_WRITE);
                field_cnt_q <= '0;
                state_q     <= GET_ADDR;
              end
              // Anything else is junk
              default: ;
            endcase
          end
        end
        GET_ADDR, GET_LEN: begin
          if (pop_o) begin
            field_cnt_q <= field_cnt_q + 1'b1;
            if (field_last) begin
              state_q <= (state_q == GET_ADDR) ? GET_LEN : SEND_ACK;
            end
          end
        end
        SEND_ACK: begin
          if (tx_req_o.valid) begin
            if (!is_cmd_q) begin
              state_q <= IDLE;
            end else if (len_q == '0) begin
              state_q <= SEND_EOT;
            end else begin
              state_q <= XFER;
            end
          end
        end
        XFER: begin
          if (step && len_q == dbg_len_t'(1)) begin
            state_q <= SEND_EOT;
          end
        end
        SEND_EOT: begin
          if (tx_req_o.valid) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address and length registers
  always_ff @(posedge clk) begin
    if (state_q == GET_ADDR && pop_o && field_cnt_q == '0) begin
      addr_q <= head_i[MEM_ADDR_W-1:0];
    end
    // Upper length bytes are dropped
    if (state_q == GET_LEN && pop_o) begin
      if (field_cnt_q == FIELD_CNT_W'(0)) begin
        len_q[7:0] <= head_i;
      end else if (field_cnt_q == FIELD_CNT_W'(1)) begin
        len_q[15:8] <= head_i;
      end
    end
    if (step) begin
      addr_q <= addr_q + 1'b1;
      len_q  <= len_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (step && is_write_q) begin
      mem_q[addr_q] <= head_i;
    end
  end

endmodule

// File: src/uart_dbg_pkg.sv
// UART debug protocol definitions
package uart_dbg_pkg;

  // Serial line timing
  localparam int CLKS_PER_BIT = 16;
  localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
  // Start bit, 8 data bits and stop bit are numbered 0 to 9
  localparam int BIT_CNT_W    = 4;
  localparam int STOP_BIT     = 9;

  // Receive buffer
  localparam int FIFO_DEPTH   = 8;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

  // Debug memory, addressed by the low address byte only
  localparam int MEM_BYTES    = 256;
  localparam int MEM_ADDR_W   = $clog2(MEM_BYTES);

  // Address and length fields are 8 bytes each, little endian
  localparam int FIELD_BYTES  = 8;
  localparam int FIELD_CNT_W  = $clog2(FIELD_BYTES);

  // Protocol byte codes
  typedef enum logic [7:0] {
    CTRL_EOT  = 8'h04,
    CTRL_ACK  = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12
  } ctrl_byte_e;

  // Command engine FSM
  typedef enum logic [2:0] {
    IDLE,
    GET_ADDR,
    GET_LEN,
    SEND_ACK,
    XFER,
    SEND_EOT
  } engine_state_e;

  // One-cycle byte strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_strobe_t;

  // Only the low 16 bits of the length field are kept
  typedef logic [15:0] dbg_len_t;

endpackage

// File: src/uart_dbg_top.sv
// UART debug top level
module uart_dbg_top (
  input  logic clk,
  input  logic reset_i,
  input  logic rx_i,
  output logic tx_o
);

  import uart_dbg_pkg::*;

  byte_strobe_t rx_byte;
  byte_strobe_t tx_req;
  logic [7:0]   fifo_head;
  logic         fifo_empty;
  logic         fifo_pop;
  logic         tx_busy;

  uart_rx u_rx (
    .clk       (clk),
    .reset_i   (reset_i),
    .rx_i      (rx_i),
    .rx_byte_o (rx_byte)
  );

  // Decouples the serial receiver from the engine
  byte_fifo u_fifo (
    .clk     (clk),
    .reset_i (reset_i),
    .push_i  (rx_byte),
    .pop_i   (fifo_pop),
    .head_o  (fifo_head),
    .empty_o (fifo_empty)
  );

  dbg_cmd_engine u_engine (
    .clk       (clk),
    .reset_i   (reset_i),
    .head_i    (fifo_head),
    .empty_i   (fifo_empty),
    .pop_o     (fifo_pop),
    .tx_req_o  (tx_req),
    .tx_busy_i (tx_busy)
  );

  uart_tx u_tx (
    .clk      (clk),
    .reset_i  (reset_i),
    .tx_req_i (tx_req),
    .busy_o   (tx_busy),
    .tx_o     (tx_o)
  );

endmodule

// File: src/uart_rx.sv
// UART receiver
module uart_rx (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       rx_i,
  output uart_dbg_pkg::byte_strobe_t rx_byte_o
);

  import uart_dbg_pkg::*;

  logic [1:0]           sync_q;
  logic                 line;
  logic                 active_q;
  logic [CLK_CNT_W-1:0] clk_cnt_q;
  logic [BIT_CNT_W-1:0] bit_cnt_q;
  logic [7:0]           shift_q;
  logic                 valid_q;
  logic                 sample;

  // Two-stage synchronizer on the asynchronous line
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign line = sync_q[1];

  // Start bit is checked at half a bit, every later bit one full bit on
  assign sample = (bit_cnt_q == '0) ? (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1))
                                    : (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      active_q  <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!active_q) begin
        // Falling edge on an idle line starts a frame
        if (!line) begin
          active_q  <= 1'b1;
          clk_cnt_q <= '0;
          bit_cnt_q <= '0;
        end
      end else if (sample) begin
        clk_cnt_q <= '0;
        if (bit_cnt_q == '0) begin
          // Glitch, not a real start bit
          if (line) begin
            active_q <= 1'b0;
          end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end else if (bit_cnt_q == BIT_CNT_W'(STOP_BIT)) begin
          active_q <= 1'b0;
          // Framing error gives no strobe
          valid_q  <= line;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (active_q && sample && bit_cnt_q != '0 && bit_cnt_q != BIT_CNT_W'(STOP_BIT)) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

  assign rx_byte_o.valid = valid_q;
  assign rx_byte_o.data  = shift_q;

endmodule

// File: src/uart_tx.sv
// UART transmitter
module uart_tx (
  input  logic                       clk,
  input  logic                       reset_i,
  input  uart_dbg_pkg::byte_strobe_t tx_req_i,
  output logic                       busy_o,
  output logic                       tx_o
);

  import uart_dbg_pkg::*;

  logic                 active_q;
  logic [CLK_CNT_W-1:0] clk_cnt_q;
  logic [BIT_CNT_W-1:0] bit_cnt_q;
  // Data bits followed by the stop bit
  logic [8:0]           shift_q;
  logic                 tx_q;
  logic                 accept;
  logic                 bit_end;

  assign accept  = tx_req_i.valid && !active_q;
  assign bit_end = active_q && (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      active_q  <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      tx_q      <= 1'b1;
    end else if (accept) begin
      // Start bit goes out right away
      active_q  <= 1'b1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      tx_q      <= 1'b0;
    end else if (bit_end) begin
      clk_cnt_q <= '0;
      if (bit_cnt_q == BIT_CNT_W'(STOP_BIT)) begin
        active_q <= 1'b0;
        tx_q     <= 1'b1;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        tx_q      <= shift_q[0];
      end
    end else if (active_q) begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  // LSB first, ones shifted in behind the stop bit
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= {1'b1, tx_req_i.data};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign busy_o = active_q;
  assign tx_o   = tx_q;

endmodule

// File: verification/tb_uart_dbg.sv
// UART debug testbench
module tb_uart_dbg;
  timeunit 1ns;
  timeprecision 1ps;

  import uart_dbg_pkg::*;

  localparam int CLK_PERIOD_NS = 10;
  localparam int RESET_CYCLES  = 5;
  localparam int TIMEOUT_MULT  = 3;
  localparam int NUM_TESTS     = 7;
  localparam logic [31:0] SEED = 32'hc9cd;

  typedef enum logic [1:0] {
    OP_CHALLENGE,
    OP_JUNK_CHALLENGE,
    OP_WRITE,
    OP_READ
  } test_op_e;

  // One table row with its expected reply shape
  typedef struct packed {
    test_op_e    op;
    logic [63:0] addr;
    logic [63:0] len;
    logic        exp_ack;
    logic        exp_data;
    logic        exp_eot;
  } test_row_t;

  logic        clk = 1'b0;
  logic        reset_i;
  logic        rx_i;
  logic        tx_o;

  test_row_t   tests [NUM_TESTS];
  logic [7:0]  model_mem [256];
  logic [7:0]  rx_q [$];
  logic [31:0] rng;
  logic        table_ready;
  int          error_count;
  int          failed_tests;

  uart_dbg_top UUT (
    .clk     (clk),
    .reset_i (reset_i),
    .rx_i    (rx_i),
    .tx_o    (tx_o)
  );

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string op_name(input test_op_e op);
    case (op)
      OP_CHALLENGE:      return "challenge";
      OP_JUNK_CHALLENGE: return "junk then challenge";
      OP_WRITE:          return "write";
      OP_READ:           return "read";
    endcase
    return "unknown";
  endfunction

  // Bytes on both lines, used to size the watchdog
  function automatic int total_bytes();
    int n;
    n = 0;
    foreach (tests[i]) begin
      case (tests[i].op)
        OP_CHALLENGE:      n += 2;
        OP_JUNK_CHALLENGE: n += 3;
        default:           n += 3 + 2 * FIELD_BYTES + int'(tests[i].len[15:0]);
      endcase
    end
    return n;
  endfunction

  task automatic fill_table();
    logic [63:0] rand_addr;
    rng = xorshift32(rng);
    // Keep an upper address byte nonzero
    rand_addr[63:32] = rng | 32'h0100_0000;
    rng = xorshift32(rng);
    rand_addr[31:0] = rng;
    tests[0] = '{OP_CHALLENGE, 64'h0, 64'h0, 1'b1, 1'b0, 1'b0};
    tests[1] = '{OP_JUNK_CHALLENGE, 64'h0, 64'h0, 1'b1, 1'b0, 1'b0};
    tests[2] = '{OP_WRITE, rand_addr, 64'd16, 1'b1, 1'b0, 1'b1};
    tests[3] = '{OP_READ, rand_addr, 64'd16, 1'b1, 1'b1, 1'b1};
    // Wraps past address 0xff
    tests[4] = '{OP_WRITE, 64'h7700_0000_0000_01f8, 64'd16, 1'b1, 1'b0, 1'b1};
    tests[5] = '{OP_READ, 64'h0000_0000_0000_00f8, 64'hffff_0000_0000_0010,
                 1'b1, 1'b1, 1'b1};
    tests[6] = '{OP_READ, 64'h0000_0000_0000_0040, 64'h0, 1'b1, 1'b0, 1'b1};
  endtask

  // One 8N1 frame on rx_i, each bit held CLKS_PER_BIT cycles
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1 rx_i = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < FIELD_BYTES; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  task automatic check_quiet_line();
    int low_cycles;
    int errs_before;
    low_cycles  = 0;
    errs_before = error_count;
    repeat (3 * 10 * CLKS_PER_BIT) begin
      @(negedge clk);
      if (tx_o !== 1'b1) begin
        low_cycles++;
      end
    end
    assert (low_cycles == 0 && rx_q.size() == 0) else begin
      $display("time %0t: tx_o left the idle level after reset with no command sent", $time);
      error_count++;
    end
    if (error_count != errs_before) begin
      failed_tests++;
    end
    $display("idle after reset: %0s", (error_count == errs_before) ? "ok" : "failed");
  endtask

  task automatic run_test(input int idx);
    test_row_t  row;
    logic [7:0] exp_q [$];
    logic [7:0] data;
    logic [7:0] a;
    int         errs_before;
    row         = tests[idx];
    errs_before = error_count;
    rx_q.delete();
    case (row.op)
      OP_CHALLENGE: begin
        send_byte(CTRL_ACK);
      end
      OP_JUNK_CHALLENGE: begin
        send_byte(8'h55);
        send_byte(CTRL_ACK);
      end
      OP_WRITE, OP_READ: begin
        send_byte((row.op == OP_WRITE) ? CMD_WRITE : CMD_READ);
        send_field(row.addr);
        send_field(row.len);
        if (row.op == OP_WRITE) begin
          for (int i = 0; i < int'(row.len[15:0]); i++) begin
            rng  = xorshift32(rng);
            data = rng[7:0];
            a    = row.addr[7:0] + 8'(i);
            model_mem[a] = data;
            send_byte(data);
          end
        end
      end
    endcase

    if (row.exp_ack) begin
      exp_q.push_back(CTRL_ACK);
    end
    if (row.exp_data) begin
      for (int i = 0; i < int'(row.len[15:0]); i++) begin
        a = row.addr[7:0] + 8'(i);
        exp_q.push_back(model_mem[a]);
      end
    end
    if (row.exp_eot) begin
      exp_q.push_back(CTRL_EOT);
    end

    while (rx_q.size() < exp_q.size()) begin
      @(posedge clk);
    end
    // Two more frame times to catch any extra reply byte
    repeat (2 * 10 * CLKS_PER_BIT) @(posedge clk);

    assert (rx_q.size() == exp_q.size()) else begin
      $display("test %0d: expected %0d reply bytes on tx_o but received %0d",
               idx, exp_q.size(), rx_q.size());
      error_count++;
    end
    for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
      assert (rx_q[i] == exp_q[i]) else begin
        $display("mismatch at %0t: tx_o reply byte %0d got 0x%02h expected 0x%02h",
                 $time, i, rx_q[i], exp_q[i]);
        error_count++;
      end
    end
    if (error_count != errs_before) begin
      failed_tests++;
    end
    $display("test %0d %0s: %0s", idx, op_name(row.op),
             (error_count == errs_before) ? "ok" : "failed");
  endtask

  // Decodes tx_o frames, sampling mid-bit on the falling clock edge
  initial begin : monitor
    logic [7:0] rx_data;
    forever begin
      @(negedge clk);
      if (reset_i === 1'b0 && tx_o === 1'b0) begin
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        for (int b = 0; b < 8; b++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          rx_data[b] = tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (tx_o === 1'b1) else begin
          $display("time %0t: tx_o frame ended with a low stop bit", $time);
          error_count++;
        end
        rx_q.push_back(rx_data);
      end
    end
  end

  initial begin : watchdog
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(total_bytes()) * 10 * CLKS_PER_BIT * CLK_PERIOD_NS * TIMEOUT_MULT;
    #(limit_ns);
    $display("timeout: the tests did not finish within %0d ns", limit_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    rx_i         = 1'b1;
    reset_i      = 1'b1;
    rng          = SEED;
    table_ready  = 1'b0;
    error_count  = 0;
    failed_tests = 0;
    fill_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_i = 1'b0;

    check_quiet_line();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS + 1, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
